// ==== all.f ====
logic/rv32_pkg.sv
logic/rv32_imm_gen.sv
logic/rv32_ctrl_decode.sv
logic/rv32_regs.sv
logic/rv32_decode.sv
verification/rv32_decode_tb.sv

// ==== logic/rv32_ctrl_decode.sv ====
`timescale 1ns/1ps

module rv32_ctrl_decode (
    input  rv32_pkg::instr_u   instr_i,
    output rv32_pkg::ctrl_t    ctrl_o,
    output rv32_pkg::imm_fmt_e imm_fmt_o
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;      // SUB or SRA pattern
    logic       slt_op;   // Compares run through the subtractor

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;
    assign alt    = (funct7 == rv32_pkg::FUNCT7_ALT);
    assign slt_op = (funct3 == rv32_pkg::FUNCT3_SLT) || (funct3 == rv32_pkg::FUNCT3_SLTU);

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.rs1       = instr_i.r.rs1;
        ctrl_o.rs2       = instr_i.r.rs2;
        ctrl_o.rd        = instr_i.r.rd;
        ctrl_o.branch_op = rv32_pkg::BR_NEVER;
        imm_fmt_o        = rv32_pkg::IMM_NONE;

        case (opcode)
            rv32_pkg::OPC_LUI: begin
                ctrl_o.valid    = 1'b1;
                ctrl_o.alu_op   = rv32_pkg::ALU_SRC2;
                ctrl_o.alu_src2 = rv32_pkg::SRC2_IMM;
                ctrl_o.rd_write = 1'b1;
                imm_fmt_o       = rv32_pkg::IMM_U;
            end
            rv32_pkg::OPC_AUIPC: begin
                ctrl_o.valid    = 1'b1;
                ctrl_o.alu_op   = rv32_pkg::ALU_ADD_SUB;
                ctrl_o.alu_src1 = rv32_pkg::SRC1_PC;
                ctrl_o.alu_src2 = rv32_pkg::SRC2_IMM;
                ctrl_o.rd_write = 1'b1;
                imm_fmt_o       = rv32_pkg::IMM_U;
            end
            rv32_pkg::OPC_JAL, rv32_pkg::OPC_JALR: begin
                if (opcode == rv32_pkg::OPC_JAL || funct3 == rv32_pkg::FUNCT3_JALR) begin
                    ctrl_o.valid     = 1'b1;
                    ctrl_o.alu_op    = rv32_pkg::ALU_SRC1P4;   // Link address
                    ctrl_o.alu_src1  = rv32_pkg::SRC1_PC;
                    ctrl_o.branch_op = rv32_pkg::BR_ALWAYS;
                    ctrl_o.rd_write  = 1'b1;
                    if (opcode == rv32_pkg::OPC_JAL) begin
                        imm_fmt_o = rv32_pkg::IMM_J;
                    end else begin
                        ctrl_o.branch_pc_src = rv32_pkg::BR_PC_REG;
                        imm_fmt_o            = rv32_pkg::IMM_I;
                    end
                end
            end
            rv32_pkg::OPC_BRANCH: begin
                case (funct3)
                    rv32_pkg::FUNCT3_BEQ, rv32_pkg::FUNCT3_BNE,
                    rv32_pkg::FUNCT3_BLT, rv32_pkg::FUNCT3_BGE,
                    rv32_pkg::FUNCT3_BLTU, rv32_pkg::FUNCT3_BGEU: ctrl_o.valid = 1'b1;
                    default: ;
                endcase
                if (ctrl_o.valid) begin
                    ctrl_o.alu_op      = !funct3[2] ? rv32_pkg::ALU_ADD_SUB :
                                         funct3[1]  ? rv32_pkg::ALU_SLTU : rv32_pkg::ALU_SLT;
                    ctrl_o.alu_sub_sra = 1'b1;
                    // BNE, BLT and BLTU take the branch on a nonzero result
                    ctrl_o.branch_op   = (funct3[2] ^ funct3[0]) ? rv32_pkg::BR_NON_ZERO
                                                                 : rv32_pkg::BR_ZERO;
                    imm_fmt_o          = rv32_pkg::IMM_B;
                end
            end
            rv32_pkg::OPC_LOAD: begin
                case (funct3)
                    rv32_pkg::FUNCT3_LB, rv32_pkg::FUNCT3_LH, rv32_pkg::FUNCT3_LW,
                    rv32_pkg::FUNCT3_LBU, rv32_pkg::FUNCT3_LHU: ctrl_o.valid = 1'b1;
                    default: ;
                endcase
                if (ctrl_o.valid) begin
                    ctrl_o.alu_src2        = rv32_pkg::SRC2_IMM;
                    ctrl_o.mem_read        = 1'b1;
                    ctrl_o.mem_width       = rv32_pkg::mem_width_e'(funct3[1:0]);
                    ctrl_o.mem_zero_extend = funct3[2];   // LBU and LHU
                    ctrl_o.rd_write        = 1'b1;
                    imm_fmt_o              = rv32_pkg::IMM_I;
                end
            end
            rv32_pkg::OPC_STORE: begin
                case (funct3)
                    rv32_pkg::FUNCT3_SB, rv32_pkg::FUNCT3_SH,
                    rv32_pkg::FUNCT3_SW: ctrl_o.valid = 1'b1;
                    default: ;
                endcase
                if (ctrl_o.valid) begin
                    ctrl_o.alu_src2  = rv32_pkg::SRC2_IMM;
                    ctrl_o.mem_write = 1'b1;
                    ctrl_o.mem_width = rv32_pkg::mem_width_e'(funct3[1:0]);
                    imm_fmt_o        = rv32_pkg::IMM_S;
                end
            end
            rv32_pkg::OPC_OP_IMM: begin
                case (funct3)
                    rv32_pkg::FUNCT3_SLL:     ctrl_o.valid = (funct7 == rv32_pkg::FUNCT7_ZERO);
                    rv32_pkg::FUNCT3_SRL_SRA: ctrl_o.valid = (funct7 == rv32_pkg::FUNCT7_ZERO) || alt;
                    default:                  ctrl_o.valid = 1'b1;
                endcase
                if (ctrl_o.valid) begin
                    ctrl_o.alu_op      = rv32_pkg::alu_op_e'({1'b0, funct3});
                    ctrl_o.alu_sub_sra = slt_op || (funct3 == rv32_pkg::FUNCT3_SRL_SRA && alt);
                    ctrl_o.alu_src2    = rv32_pkg::SRC2_IMM;
                    ctrl_o.rd_write    = 1'b1;
                    imm_fmt_o          = (funct3[1:0] == 2'b01) ? rv32_pkg::IMM_SHAMT
                                                                : rv32_pkg::IMM_I;
                end
            end
            rv32_pkg::OPC_OP: begin
                case (funct3)
                    rv32_pkg::FUNCT3_ADD_SUB,
                    rv32_pkg::FUNCT3_SRL_SRA: ctrl_o.valid = (funct7 == rv32_pkg::FUNCT7_ZERO) || alt;
                    default:                  ctrl_o.valid = (funct7 == rv32_pkg::FUNCT7_ZERO);
                endcase
                if (ctrl_o.valid) begin
                    ctrl_o.alu_op      = rv32_pkg::alu_op_e'({1'b0, funct3});
                    ctrl_o.alu_sub_sra = slt_op || alt;
                    ctrl_o.rd_write    = 1'b1;
                end
            end
            rv32_pkg::OPC_MISC_MEM: begin
                // FENCE and FENCE.I are no-ops in an in-order pipeline
                ctrl_o.valid = (funct3 == rv32_pkg::FUNCT3_FENCE) ||
                               (funct3 == rv32_pkg::FUNCT3_FENCE_I);
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/rv32_decode.sv ====
`timescale 1ns/1ps

module rv32_decode (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            stall_i,
    input  logic                            flush_i,
    input  logic [rv32_pkg::XLEN-1:0]       pc_i,
    input  rv32_pkg::instr_u                instr_i,
    input  rv32_pkg::wb_t                   wb_i,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rs1_unreg_o,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rs2_unreg_o,
    output rv32_pkg::ctrl_t                 ctrl_o,
    output rv32_pkg::data_t                 data_o
);
    rv32_pkg::ctrl_t           ctrl_dec;
    rv32_pkg::ctrl_t           ctrl_next;
    rv32_pkg::imm_fmt_e        imm_fmt;
    logic [rv32_pkg::XLEN-1:0] imm;
    logic [rv32_pkg::XLEN-1:0] rs1_value;
    logic [rv32_pkg::XLEN-1:0] rs2_value;
    rv32_pkg::ctrl_t           ctrl_q;
    logic [rv32_pkg::XLEN-1:0] pc_q;
    logic [rv32_pkg::XLEN-1:0] imm_q;

    // Hazard unit needs the indices before the stage register
    assign rs1_unreg_o = instr_i.r.rs1;
    assign rs2_unreg_o = instr_i.r.rs2;

    rv32_ctrl_decode i_ctrl_decode (
        .instr_i   (instr_i),
        .ctrl_o    (ctrl_dec),
        .imm_fmt_o (imm_fmt)
    );

    rv32_imm_gen i_imm_gen (
        .instr_i   (instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    rv32_regs i_regs (
        .clk         (clk),
        .stall_i     (stall_i),
        .rs1_i       (instr_i.r.rs1),
        .rs2_i       (instr_i.r.rs2),
        .wb_i        (wb_i),
        .rs1_value_o (rs1_value),
        .rs2_value_o (rs2_value)
    );

    // **********************************************************************
    // Stage register
    // **********************************************************************

    always_comb begin
        ctrl_next = ctrl_dec;
        if (flush_i) begin   // Keep valid, drop side-effects
            ctrl_next.mem_read  = 1'b0;
            ctrl_next.mem_write = 1'b0;
            ctrl_next.rd_write  = 1'b0;
            ctrl_next.branch_op = rv32_pkg::BR_NEVER;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_q           <= '0;
            ctrl_q.branch_op <= rv32_pkg::BR_NEVER;
        end else if (!stall_i) begin
            ctrl_q <= ctrl_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_q  <= pc_i;
            imm_q <= imm;
        end
    end

    assign ctrl_o = ctrl_q;
    assign data_o = '{pc: pc_q, rs1_value: rs1_value, rs2_value: rs2_value, imm: imm_q};

endmodule

// ==== logic/rv32_imm_gen.sv ====
`timescale 1ns/1ps

module rv32_imm_gen (
    input  rv32_pkg::instr_u          instr_i,
    input  rv32_pkg::imm_fmt_e        imm_fmt_i,
    output logic [rv32_pkg::XLEN-1:0] imm_o
);
    rv32_pkg::r_fmt_t r;
    rv32_pkg::s_fmt_t s;
    logic             sign;

    assign r    = instr_i.r;
    assign s    = instr_i.s;
    assign sign = r.funct7[6];   // Instruction bit 31

    always_comb begin
        case (imm_fmt_i)
            rv32_pkg::IMM_I: begin
                imm_o = {{20{sign}}, r.funct7, r.rs2};
            end
            rv32_pkg::IMM_S: begin
                imm_o = {{20{sign}}, s.imm_hi, s.imm_lo};
            end
            rv32_pkg::IMM_B: begin
                imm_o = {{20{sign}}, s.imm_lo[0], s.imm_hi[5:0], s.imm_lo[4:1], 1'b0};
            end
            rv32_pkg::IMM_U: begin
                imm_o = {r.funct7, r.rs2, r.rs1, r.funct3, 12'b0};
            end
            rv32_pkg::IMM_J: begin
                imm_o = {{12{sign}}, r.rs1, r.funct3, r.rs2[0], r.funct7[5:0],
                         r.rs2[4:1], 1'b0};
            end
            rv32_pkg::IMM_SHAMT: begin
                imm_o = {{(rv32_pkg::XLEN - rv32_pkg::REG_ADDR_W){1'b0}}, r.rs2};
            end
            default: begin
                imm_o = '0;   // No immediate
            end
        endcase
    end

endmodule

// ==== logic/rv32_pkg.sv ====
package rv32_pkg;

    // **********************************************************************
    // Widths
    // **********************************************************************

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    // **********************************************************************
    // Opcodes and function codes
    // **********************************************************************

    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

    localparam logic [2:0] FUNCT3_JALR = 3'b000;

    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    localparam logic [2:0] FUNCT3_LB  = 3'b000;
    localparam logic [2:0] FUNCT3_LH  = 3'b001;
    localparam logic [2:0] FUNCT3_LW  = 3'b010;
    localparam logic [2:0] FUNCT3_LBU = 3'b100;
    localparam logic [2:0] FUNCT3_LHU = 3'b101;

    localparam logic [2:0] FUNCT3_SB = 3'b000;
    localparam logic [2:0] FUNCT3_SH = 3'b001;
    localparam logic [2:0] FUNCT3_SW = 3'b010;

    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    localparam logic [2:0] FUNCT3_FENCE   = 3'b000;
    localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;

    localparam logic [6:0] FUNCT7_ZERO = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;   // SUB and SRA

    // **********************************************************************
    // Control encodings
    // **********************************************************************

    // First eight follow the funct3 order of OP and OP-IMM
    typedef enum logic [3:0] {
        ALU_ADD_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL_SRA, ALU_OR, ALU_AND,
        ALU_SRC2, ALU_SRC1P4
    } alu_op_e;

    typedef enum logic {SRC1_REG, SRC1_PC} alu_src1_e;
    typedef enum logic {SRC2_REG, SRC2_IMM} alu_src2_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_width_e;

    typedef enum logic [1:0] {BR_NEVER, BR_ZERO, BR_NON_ZERO, BR_ALWAYS} branch_op_e;

    typedef enum logic {BR_PC_IMM, BR_PC_REG} branch_pc_src_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT, IMM_NONE
    } imm_fmt_e;

    // **********************************************************************
    // Instruction word and stage bundles
    // **********************************************************************

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;
        s_fmt_t s;
    } instr_u;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic                  alu_sub_sra;
        alu_src1_e             alu_src1;
        alu_src2_e             alu_src2;
        logic                  mem_read;
        logic                  mem_write;
        mem_width_e            mem_width;
        logic                  mem_zero_extend;
        branch_op_e            branch_op;
        branch_pc_src_e        branch_pc_src;
        logic                  rd_write;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_value;
        logic [XLEN-1:0] rs2_value;
        logic [XLEN-1:0] imm;
    } data_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_write;
        logic [XLEN-1:0]       rd_value;
    } wb_t;

endpackage

// ==== logic/rv32_regs.sv ====
`timescale 1ns/1ps

module rv32_regs (
    input  logic                            clk,
    input  logic                            stall_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rs2_i,
    input  rv32_pkg::wb_t                   wb_i,
    output logic [rv32_pkg::XLEN-1:0]       rs1_value_o,
    output logic [rv32_pkg::XLEN-1:0]       rs2_value_o
);
    logic [rv32_pkg::XLEN-1:0] regs_q [rv32_pkg::REG_COUNT];
    logic                      wr_en;

    assign wr_en = wb_i.rd_write && (wb_i.rd != '0);   // x0 is never written

    function automatic logic [rv32_pkg::XLEN-1:0] read_port(
        input logic [rv32_pkg::REG_ADDR_W-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end
        if (wr_en && idx == wb_i.rd) begin
            return wb_i.rd_value;   // Write-through
        end
        return regs_q[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.rd_value;   // Writes ignore stall
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rs1_value_o <= read_port(rs1_i);
            rs2_value_o <= read_port(rs2_i);
        end
    end

endmodule

// ==== verification/rv32_decode_tb.sv ====
`timescale 1ns/1ps

module rv32_decode_tb;

    localparam int          CLK_PERIOD = 40;
    localparam int          N_INSTR    = 39;
    localparam logic [31:0] M_OPC      = 32'h0000_007f;   // Opcode only
    localparam logic [31:0] M_F3       = 32'h0000_707f;   // Opcode and funct3
    localparam logic [31:0] M_F7       = 32'hfe00_707f;   // Opcode, funct3 and funct7

    // Cycle budget of each test
    localparam int CYC_RESET  = 10;
    localparam int CYC_REGS   = 140;
    localparam int CYC_IMM    = 100;
    localparam int CYC_CTRL   = 170;
    localparam int CYC_STALL  = 30;
    localparam int TIMEOUT_NS = 2 * (CYC_RESET + CYC_REGS + CYC_IMM + CYC_CTRL + CYC_STALL)
                                * CLK_PERIOD;

    logic                            clk;
    logic                            reset_i;
    logic                            stall_i;
    logic                            flush_i;
    logic [rv32_pkg::XLEN-1:0]       pc_i;
    rv32_pkg::instr_u                instr_i;
    rv32_pkg::wb_t                   wb_i;
    logic [rv32_pkg::REG_ADDR_W-1:0] rs1_unreg_o;
    logic [rv32_pkg::REG_ADDR_W-1:0] rs2_unreg_o;
    rv32_pkg::ctrl_t                 ctrl_o;
    rv32_pkg::data_t                 data_o;

    integer             seed = 28;
    int                 errors;
    int                 checks;
    int                 n_instr;
    int                 e0;
    int                 idx;
    string              instr_name [N_INSTR];
    logic [31:0]        instr_val [N_INSTR];
    logic [31:0]        instr_mask [N_INSTR];
    rv32_pkg::ctrl_t    instr_ctrl [N_INSTR];   // Expected control, indices left zero
    rv32_pkg::imm_fmt_e instr_fmt [N_INSTR];
    logic [31:0]        reg_model [rv32_pkg::REG_COUNT];
    rv32_pkg::wb_t      wbs;
    rv32_pkg::ctrl_t    snap_c;
    rv32_pkg::data_t    snap_d;
    string              fmt_instr [6] = '{"ADDI", "SW", "BEQ", "LUI", "JAL", "SLLI"};
    string              flush_instr [5] = '{"LW", "SW", "BEQ", "ADD", "JAL"};

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    rv32_decode i_rv32_decode (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .wb_i        (wb_i),
        .rs1_unreg_o (rs1_unreg_o),
        .rs2_unreg_o (rs2_unreg_o),
        .ctrl_o      (ctrl_o),
        .data_o      (data_o)
    );

    // **********************************************************************
    // Reference rules
    // **********************************************************************

    function automatic logic [31:0] ref_imm(logic [31:0] w, rv32_pkg::imm_fmt_e fmt);
        case (fmt)
            rv32_pkg::IMM_I:     return {{20{w[31]}}, w[31:20]};
            rv32_pkg::IMM_S:     return {{20{w[31]}}, w[31:25], w[11:7]};
            rv32_pkg::IMM_B:     return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            rv32_pkg::IMM_U:     return {w[31:12], 12'b0};
            rv32_pkg::IMM_J:     return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            rv32_pkg::IMM_SHAMT: return {27'b0, w[24:20]};
            default:             return 32'b0;
        endcase
    endfunction

    function automatic logic [31:0] reg_value(logic [4:0] r);
        return (r == 5'd0) ? 32'b0 : reg_model[r];
    endfunction

    function automatic logic [31:0] random_word(int i);
        return ($random(seed) & ~instr_mask[i]) | instr_val[i];
    endfunction

    function automatic logic [31:0] rr_word(logic [4:0] rs1, logic [4:0] rs2, logic [4:0] rd);
        return {rv32_pkg::FUNCT7_ZERO, rs2, rs1, rv32_pkg::FUNCT3_ADD_SUB, rd, rv32_pkg::OPC_OP};
    endfunction

    function automatic int find_instr(string nm);
        for (int i = 0; i < n_instr; i++) begin
            if (instr_name[i] == nm) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic store_entry(string nm, logic [31:0] val, logic [31:0] mask,
                               rv32_pkg::ctrl_t c, rv32_pkg::imm_fmt_e fmt);
        c.valid             = 1'b1;
        instr_name[n_instr] = nm;
        instr_val[n_instr]  = val;
        instr_mask[n_instr] = mask;
        instr_ctrl[n_instr] = c;
        instr_fmt[n_instr]  = fmt;
        n_instr++;
    endtask

    task automatic alu_entry(string nm, logic [31:0] val, logic [31:0] mask,
                             rv32_pkg::alu_op_e op, logic sub, rv32_pkg::imm_fmt_e fmt);
        rv32_pkg::ctrl_t c;
        c             = '0;
        c.alu_op      = op;
        c.alu_sub_sra = sub;
        c.alu_src2    = (fmt == rv32_pkg::IMM_NONE) ? rv32_pkg::SRC2_REG : rv32_pkg::SRC2_IMM;
        c.rd_write    = 1'b1;
        store_entry(nm, val, mask, c, fmt);
    endtask

    task automatic mem_entry(string nm, logic [31:0] val, logic store,
                             rv32_pkg::mem_width_e width, logic zext);
        rv32_pkg::ctrl_t c;
        c                 = '0;
        c.alu_src2        = rv32_pkg::SRC2_IMM;   // Address is rs1 plus offset
        c.mem_read        = !store;
        c.mem_write       = store;
        c.mem_width       = width;
        c.mem_zero_extend = zext;
        c.rd_write        = !store;
        store_entry(nm, val, M_F3, c, store ? rv32_pkg::IMM_S : rv32_pkg::IMM_I);
    endtask

    task automatic branch_entry(string nm, logic [31:0] val, rv32_pkg::alu_op_e op,
                                rv32_pkg::branch_op_e br);
        rv32_pkg::ctrl_t c;
        c             = '0;
        c.alu_op      = op;
        c.alu_sub_sra = 1'b1;   // Compare by subtraction
        c.branch_op   = br;
        store_entry(nm, val, M_F3, c, rv32_pkg::IMM_B);
    endtask

    task automatic jump_entry(string nm, logic [31:0] val, logic [31:0] mask,
                              rv32_pkg::branch_pc_src_e src, rv32_pkg::imm_fmt_e fmt);
        rv32_pkg::ctrl_t c;
        c               = '0;
        c.alu_op        = rv32_pkg::ALU_SRC1P4;   // Link value pc + 4
        c.alu_src1      = rv32_pkg::SRC1_PC;
        c.branch_op     = rv32_pkg::BR_ALWAYS;
        c.branch_pc_src = src;
        c.rd_write      = 1'b1;
        store_entry(nm, val, mask, c, fmt);
    endtask

    task automatic build_table();
        alu_entry("LUI", 32'h0000_0037, M_OPC, rv32_pkg::ALU_SRC2, 1'b0, rv32_pkg::IMM_U);
        alu_entry("AUIPC", 32'h0000_0017, M_OPC, rv32_pkg::ALU_ADD_SUB, 1'b0, rv32_pkg::IMM_U);
        instr_ctrl[n_instr-1].alu_src1 = rv32_pkg::SRC1_PC;
        jump_entry("JAL", 32'h0000_006f, M_OPC, rv32_pkg::BR_PC_IMM, rv32_pkg::IMM_J);
        jump_entry("JALR", 32'h0000_0067, M_F3, rv32_pkg::BR_PC_REG, rv32_pkg::IMM_I);
        branch_entry("BEQ", 32'h0000_0063, rv32_pkg::ALU_ADD_SUB, rv32_pkg::BR_ZERO);
        branch_entry("BNE", 32'h0000_1063, rv32_pkg::ALU_ADD_SUB, rv32_pkg::BR_NON_ZERO);
        branch_entry("BLT", 32'h0000_4063, rv32_pkg::ALU_SLT, rv32_pkg::BR_NON_ZERO);
        branch_entry("BGE", 32'h0000_5063, rv32_pkg::ALU_SLT, rv32_pkg::BR_ZERO);
        branch_entry("BLTU", 32'h0000_6063, rv32_pkg::ALU_SLTU, rv32_pkg::BR_NON_ZERO);
        branch_entry("BGEU", 32'h0000_7063, rv32_pkg::ALU_SLTU, rv32_pkg::BR_ZERO);
        mem_entry("LB", 32'h0000_0003, 1'b0, rv32_pkg::MEM_BYTE, 1'b0);
        mem_entry("LH", 32'h0000_1003, 1'b0, rv32_pkg::MEM_HALF, 1'b0);
        mem_entry("LW", 32'h0000_2003, 1'b0, rv32_pkg::MEM_WORD, 1'b0);
        mem_entry("LBU", 32'h0000_4003, 1'b0, rv32_pkg::MEM_BYTE, 1'b1);
        mem_entry("LHU", 32'h0000_5003, 1'b0, rv32_pkg::MEM_HALF, 1'b1);
        mem_entry("SB", 32'h0000_0023, 1'b1, rv32_pkg::MEM_BYTE, 1'b0);
        mem_entry("SH", 32'h0000_1023, 1'b1, rv32_pkg::MEM_HALF, 1'b0);
        mem_entry("SW", 32'h0000_2023, 1'b1, rv32_pkg::MEM_WORD, 1'b0);
        alu_entry("ADDI", 32'h0000_0013, M_F3, rv32_pkg::ALU_ADD_SUB, 1'b0, rv32_pkg::IMM_I);
        alu_entry("SLTI", 32'h0000_2013, M_F3, rv32_pkg::ALU_SLT, 1'b1, rv32_pkg::IMM_I);
        alu_entry("SLTIU", 32'h0000_3013, M_F3, rv32_pkg::ALU_SLTU, 1'b1, rv32_pkg::IMM_I);
        alu_entry("XORI", 32'h0000_4013, M_F3, rv32_pkg::ALU_XOR, 1'b0, rv32_pkg::IMM_I);
        alu_entry("ORI", 32'h0000_6013, M_F3, rv32_pkg::ALU_OR, 1'b0, rv32_pkg::IMM_I);
        alu_entry("ANDI", 32'h0000_7013, M_F3, rv32_pkg::ALU_AND, 1'b0, rv32_pkg::IMM_I);
        alu_entry("SLLI", 32'h0000_1013, M_F7, rv32_pkg::ALU_SLL, 1'b0, rv32_pkg::IMM_SHAMT);
        alu_entry("SRLI", 32'h0000_5013, M_F7, rv32_pkg::ALU_SRL_SRA, 1'b0, rv32_pkg::IMM_SHAMT);
        alu_entry("SRAI", 32'h4000_5013, M_F7, rv32_pkg::ALU_SRL_SRA, 1'b1, rv32_pkg::IMM_SHAMT);
        alu_entry("ADD", 32'h0000_0033, M_F7, rv32_pkg::ALU_ADD_SUB, 1'b0, rv32_pkg::IMM_NONE);
        alu_entry("SUB", 32'h4000_0033, M_F7, rv32_pkg::ALU_ADD_SUB, 1'b1, rv32_pkg::IMM_NONE);
        alu_entry("SLL", 32'h0000_1033, M_F7, rv32_pkg::ALU_SLL, 1'b0, rv32_pkg::IMM_NONE);
        alu_entry("SLT", 32'h0000_2033, M_F7, rv32_pkg::ALU_SLT, 1'b1, rv32_pkg::IMM_NONE);
        alu_entry("SLTU", 32'h0000_3033, M_F7, rv32_pkg::ALU_SLTU, 1'b1, rv32_pkg::IMM_NONE);
        alu_entry("XOR", 32'h0000_4033, M_F7, rv32_pkg::ALU_XOR, 1'b0, rv32_pkg::IMM_NONE);
        alu_entry("SRL", 32'h0000_5033, M_F7, rv32_pkg::ALU_SRL_SRA, 1'b0, rv32_pkg::IMM_NONE);
        alu_entry("SRA", 32'h4000_5033, M_F7, rv32_pkg::ALU_SRL_SRA, 1'b1, rv32_pkg::IMM_NONE);
        alu_entry("OR", 32'h0000_6033, M_F7, rv32_pkg::ALU_OR, 1'b0, rv32_pkg::IMM_NONE);
        alu_entry("AND", 32'h0000_7033, M_F7, rv32_pkg::ALU_AND, 1'b0, rv32_pkg::IMM_NONE);
        store_entry("FENCE", 32'h0000_000f, M_F3, '0, rv32_pkg::IMM_NONE);
        store_entry("FENCE.I", 32'h0000_100f, M_F3, '0, rv32_pkg::IMM_NONE);
    endtask

    // **********************************************************************
    // Checks and stimulus
    // **********************************************************************

    task automatic check_val(string sig, logic [127:0] exp, logic [127:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %0t %s expected %0h actual %0h", $time, sig, exp, act);
        end
    endtask

    // One instruction through the capturing edge
    task automatic decode_step(int idx, logic [31:0] w, logic fl, rv32_pkg::wb_t wb);
        rv32_pkg::ctrl_t    exp_c;
        rv32_pkg::imm_fmt_e fmt;
        logic [31:0]        pc;
        pc    = $random(seed);
        exp_c = '0;
        fmt   = rv32_pkg::IMM_NONE;
        if (idx >= 0) begin   // Negative idx marks an illegal encoding
            exp_c = instr_ctrl[idx];
            fmt   = instr_fmt[idx];
        end
        exp_c.rs1 = w[19:15];
        exp_c.rs2 = w[24:20];
        exp_c.rd  = w[11:7];
        if (fl) begin   // Flushed slot keeps valid only
            exp_c.mem_read  = 1'b0;
            exp_c.mem_write = 1'b0;
            exp_c.rd_write  = 1'b0;
            exp_c.branch_op = rv32_pkg::BR_NEVER;
        end
        @(posedge clk);
        instr_i <= w;
        pc_i    <= pc;
        wb_i    <= wb;
        flush_i <= fl;
        stall_i <= 1'b0;
        if (wb.rd_write && wb.rd != 5'd0) reg_model[wb.rd] = wb.rd_value;
        @(negedge clk);
        check_val("rs1_unreg_o", w[19:15], rs1_unreg_o);
        check_val("rs2_unreg_o", w[24:20], rs2_unreg_o);
        @(posedge clk);
        @(negedge clk);
        check_val("ctrl_o", exp_c, ctrl_o);
        check_val("data_o.pc", pc, data_o.pc);
        check_val("data_o.imm", ref_imm(w, fmt), data_o.imm);
        check_val("data_o.rs1_value", reg_value(w[19:15]), data_o.rs1_value);
        check_val("data_o.rs2_value", reg_value(w[24:20]), data_o.rs2_value);
    endtask

    task automatic report_test(string nm, int err_before);
        $display("test %-8s done, %0d errors", nm, errors - err_before);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        n_instr = 0;
        reset_i = 1'b1;
        stall_i = 1'b1;   // Reset has to win over stall
        flush_i = 1'b0;
        pc_i    = '0;
        instr_i = '0;
        wb_i    = '0;
        build_table();

        e0 = errors;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        stall_i <= 1'b0;
        @(negedge clk);
        check_val("ctrl_o.valid", 1'b0, ctrl_o.valid);
        check_val("ctrl_o.mem_read", 1'b0, ctrl_o.mem_read);
        check_val("ctrl_o.mem_write", 1'b0, ctrl_o.mem_write);
        check_val("ctrl_o.rd_write", 1'b0, ctrl_o.rd_write);
        check_val("ctrl_o.branch_op", rv32_pkg::BR_NEVER, ctrl_o.branch_op);
        report_test("reset", e0);

        e0  = errors;
        idx = find_instr("ADD");
        for (int r = 1; r < rv32_pkg::REG_COUNT; r++) begin
            wbs.rd       = 5'(r);
            wbs.rd_write = 1'b1;
            wbs.rd_value = $random(seed);
            decode_step(idx, rr_word(5'd0, 5'd0, 5'(r)), 1'b0, wbs);
        end
        wbs.rd       = 5'd0;   // x0 stays zero
        wbs.rd_value = $random(seed);
        decode_step(idx, rr_word(5'd0, 5'd0, 5'd0), 1'b0, wbs);
        for (int i = 0; i < rv32_pkg::REG_COUNT; i++) begin
            decode_step(idx, rr_word(5'(i), 5'(31 - i), 5'($random(seed))), 1'b0, '0);
        end
        wbs.rd       = 5'd5;   // Same-edge write and read
        wbs.rd_value = $random(seed);
        decode_step(idx, rr_word(5'd5, 5'd7, 5'd1), 1'b0, wbs);
        report_test("regs", e0);

        e0 = errors;
        foreach (fmt_instr[f]) begin
            idx = find_instr(fmt_instr[f]);
            repeat (8) decode_step(idx, random_word(idx), 1'b0, '0);
        end
        report_test("imm", e0);

        e0 = errors;
        for (int i = 0; i < n_instr; i++) begin
            repeat (2) decode_step(i, random_word(i), 1'b0, '0);
        end
        decode_step(-1, ($random(seed) & ~M_OPC) | 32'h0000_007f, 1'b0, '0);
        decode_step(-1, ($random(seed) & ~M_F7) | 32'h4000_1013, 1'b0, '0);
        report_test("ctrl", e0);

        e0  = errors;
        idx = find_instr("LW");
        decode_step(idx, random_word(idx) | 32'h0000_8000, 1'b0, '0);   // Base register nonzero
        snap_c = ctrl_o;
        snap_d = data_o;
        repeat (4) begin
            @(posedge clk);
            stall_i      <= 1'b1;
            instr_i      <= $random(seed);
            wbs.rd       = snap_c.rs1;   // Write lands but the pending read holds
            wbs.rd_write = 1'b1;
            wbs.rd_value = $random(seed);
            wb_i         <= wbs;
            if (wbs.rd != 5'd0) reg_model[wbs.rd] = wbs.rd_value;
            @(negedge clk);
            check_val("ctrl_o", snap_c, ctrl_o);
            check_val("data_o", snap_d, data_o);
        end
        // Writes made under stall are visible afterwards
        decode_step(find_instr("ADD"), rr_word(snap_c.rs1, 5'd0, 5'd0), 1'b0, '0);
        foreach (flush_instr[f]) begin
            idx = find_instr(flush_instr[f]);
            decode_step(idx, random_word(idx), 1'b1, '0);
        end
        report_test("stall", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

endmodule
